// File: common/noc_pkg.sv
`default_nettype none

package noc_pkg;

   // port index, also the bit position in every port mask
   typedef enum logic [2:0] {
      PORT_N = 3'd0,
      PORT_S = 3'd1,
      PORT_W = 3'd2,
      PORT_E = 3'd3,
      PORT_L = 3'd4
   } port_e;

   localparam int NUM_PORTS = 5;

   localparam int COORD_W = 2; // one mesh coordinate, x or y

   localparam int PAYLOAD_W = 16;

   // single-flit packet, the destination travels with the data
   typedef struct packed {
      logic [COORD_W-1:0]   dst_x;
      logic [COORD_W-1:0]   dst_y;
      logic [PAYLOAD_W-1:0] payload;
   } flit_t;

   // forward link, the credit runs on its own wire the other way
   typedef struct packed {
      logic  valid;
      flit_t flit;
   } link_t;

   // one bit per port, bit index follows port_e
   typedef logic [NUM_PORTS-1:0] port_mask_t;

endpackage

`default_nettype wire

// File: router/input_port.sv
`timescale 1ns/1ns
`default_nettype none

module input_port #(
   parameter logic [noc_pkg::COORD_W-1:0] ROUTER_X  = '0,
   parameter logic [noc_pkg::COORD_W-1:0] ROUTER_Y  = '0,
   parameter int                          BUF_DEPTH = 4
) (
   input  logic                clk_i,
   input  logic                rst_i,
   input  noc_pkg::link_t      link_i,
   output logic                credit_o,
   output noc_pkg::port_mask_t req_o,
   output noc_pkg::flit_t      head_o,
   input  logic                pop_i
);

   import noc_pkg::*;

   localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
   localparam int CNT_W = $clog2(BUF_DEPTH + 1);

   flit_t            mem [BUF_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             empty;
   logic             push;
   logic             pop;
   flit_t            head;

   assign empty  = (count == '0);
   assign push   = link_i.valid; // upstream only sends while it holds a credit
   assign pop    = pop_i & ~empty;
   assign head   = mem[rd_ptr];
   assign head_o = head;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(BUF_DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem[wr_ptr] <= link_i.flit;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         credit_o <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         credit_o <= pop; // one slot freed, one credit back upstream
      end
   end

   // dimension-ordered routing, x is resolved before y
   always_comb begin
      req_o = '0;
      if (!empty) begin
         if (head.dst_x > ROUTER_X) begin
            req_o[PORT_E] = 1'b1;
         end else if (head.dst_x < ROUTER_X) begin
            req_o[PORT_W] = 1'b1;
         end else if (head.dst_y > ROUTER_Y) begin
            req_o[PORT_N] = 1'b1; // north is the larger y
         end else if (head.dst_y < ROUTER_Y) begin
            req_o[PORT_S] = 1'b1;
         end else begin
            req_o[PORT_L] = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: router/switch_allocator.sv
`timescale 1ns/1ns
`default_nettype none

module switch_allocator (
   input  logic                clk_i,
   input  logic                rst_i,
   input  noc_pkg::port_mask_t req_i   [noc_pkg::NUM_PORTS],
   input  noc_pkg::port_mask_t ready_i,
   output noc_pkg::port_mask_t grant_o [noc_pkg::NUM_PORTS],
   output noc_pkg::port_mask_t pop_o
);

   import noc_pkg::*;

   logic [2:0] last_q  [NUM_PORTS]; // last winning input per output
   logic [2:0] win_idx [NUM_PORTS];
   port_mask_t win_any;

   // each output scans the inputs starting one past its last winner
   always_comb begin
      int   idx;
      logic found;
      for (int o = 0; o < NUM_PORTS; o++) begin
         grant_o[o] = '0;
         win_idx[o] = last_q[o];
         win_any[o] = 1'b0;
         found      = 1'b0;
         for (int k = 1; k <= NUM_PORTS; k++) begin
            idx = int'(last_q[o]) + k;
            if (idx >= NUM_PORTS) begin
               idx = idx - NUM_PORTS;
            end
            if (!found && ready_i[o] && req_i[idx][o]) begin
               grant_o[o][idx] = 1'b1;
               win_idx[o]      = 3'(idx);
               found           = 1'b1;
            end
         end
         win_any[o] = found;
      end
   end

   // an input asks for one output only, so it never wins twice
   always_comb begin
      pop_o = '0;
      for (int i = 0; i < NUM_PORTS; i++) begin
         for (int o = 0; o < NUM_PORTS; o++) begin
            pop_o[i] = pop_o[i] | grant_o[o][i];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         for (int o = 0; o < NUM_PORTS; o++) begin
            last_q[o] <= 3'(NUM_PORTS - 1); // first scan starts at input 0
         end
      end else begin
         for (int o = 0; o < NUM_PORTS; o++) begin
            if (win_any[o]) begin
               last_q[o] <= win_idx[o];
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: router/crossbar_switch.sv
`timescale 1ns/1ns
`default_nettype none

module crossbar_switch (
   input  noc_pkg::flit_t      head_i  [noc_pkg::NUM_PORTS],
   input  noc_pkg::port_mask_t grant_i [noc_pkg::NUM_PORTS],
   output noc_pkg::link_t      link_o  [noc_pkg::NUM_PORTS]
);

   import noc_pkg::*;

   // one mux per output, grants are one-hot so at most one input matches
   always_comb begin
      for (int o = 0; o < NUM_PORTS; o++) begin
         link_o[o] = '0;
         for (int i = 0; i < NUM_PORTS; i++) begin
            if (i != o && grant_i[o][i]) begin // no path back out the same port
               link_o[o].valid = 1'b1;
               link_o[o].flit  = head_i[i];
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: router/output_port.sv
`timescale 1ns/1ns
`default_nettype none

module output_port #(
   parameter int BUF_DEPTH = 4
) (
   input  logic           clk_i,
   input  logic           rst_i,
   input  noc_pkg::link_t link_i,
   input  logic           credit_i,
   output logic           ready_o,
   output noc_pkg::link_t link_o
);

   import noc_pkg::*;

   localparam int CNT_W = $clog2(BUF_DEPTH + 1);

   logic             valid_q;
   flit_t            flit_q;
   logic [CNT_W-1:0] credits; // free slots in the downstream buffer

   always_ff @(posedge clk_i) begin
      if (link_i.valid) begin
         flit_q <= link_i.flit;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         valid_q <= 1'b0;
         credits <= CNT_W'(BUF_DEPTH);
      end else begin
         valid_q <= link_i.valid; // high for one cycle per granted flit
         case ({link_i.valid, credit_i})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits; // send and return cancel out
         endcase
      end
   end

   assign ready_o      = (credits != '0);
   assign link_o.valid = valid_q;
   assign link_o.flit  = flit_q;

endmodule

`default_nettype wire

// File: source/mesh_router.sv
`timescale 1ns/1ns
`default_nettype none

module mesh_router #(
   parameter logic [noc_pkg::COORD_W-1:0] ROUTER_X  = 1,
   parameter logic [noc_pkg::COORD_W-1:0] ROUTER_Y  = 1,
   parameter int                          BUF_DEPTH = 4
) (
   input  logic                clk_i,
   input  logic                rst_i,
   input  noc_pkg::link_t      in_link_i  [noc_pkg::NUM_PORTS],
   output noc_pkg::port_mask_t credit_o,
   output noc_pkg::link_t      out_link_o [noc_pkg::NUM_PORTS],
   input  noc_pkg::port_mask_t credit_i
);

   import noc_pkg::*;

   port_mask_t req       [NUM_PORTS]; // indexed by input
   flit_t      head      [NUM_PORTS];
   port_mask_t grant     [NUM_PORTS]; // indexed by output
   port_mask_t pop;
   port_mask_t ready;
   link_t      xbar_link [NUM_PORTS];

   for (genvar p = 0; p < NUM_PORTS; p++) begin : g_in
      input_port #(
         .ROUTER_X  (ROUTER_X),
         .ROUTER_Y  (ROUTER_Y),
         .BUF_DEPTH (BUF_DEPTH)
      ) u_input_port (
         .clk_i    (clk_i),
         .rst_i    (rst_i),
         .link_i   (in_link_i[p]),
         .credit_o (credit_o[p]),
         .req_o    (req[p]),
         .head_o   (head[p]),
         .pop_i    (pop[p])
      );
   end

   switch_allocator u_switch_allocator (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .req_i   (req),
      .ready_i (ready),
      .grant_o (grant),
      .pop_o   (pop)
   );

   crossbar_switch u_crossbar_switch (
      .head_i  (head),
      .grant_i (grant),
      .link_o  (xbar_link)
   );

   for (genvar p = 0; p < NUM_PORTS; p++) begin : g_out
      output_port #(
         .BUF_DEPTH (BUF_DEPTH)
      ) u_output_port (
         .clk_i    (clk_i),
         .rst_i    (rst_i),
         .link_i   (xbar_link[p]),
         .credit_i (credit_i[p]),
         .ready_o  (ready[p]),
         .link_o   (out_link_o[p])
      );
   end

endmodule

`default_nettype wire

// File: bench/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_gen #(
   parameter int PERIOD_NS = 40
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

endmodule

`default_nettype wire

// File: bench/tb_mesh_router.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mesh_router;

   import noc_pkg::*;

   localparam logic [COORD_W-1:0] ROUTER_X = 2'd1;
   localparam logic [COORD_W-1:0] ROUTER_Y = 2'd1;
   localparam int BUF_DEPTH      = 4;
   localparam int RESET_CYCLES   = 8;
   localparam int TRAFFIC_CYCLES = 3000;
   localparam int HOLD_PERIOD    = 500; // each window ends with all credits withheld
   localparam int HOLD_LENGTH    = 120;
   localparam int DRAIN_MARGIN   = 2000;
   localparam int QUIET_CYCLES   = 16; // idle cycles in a row that end the drain

   logic       clk;
   logic       rst;
   link_t      in_link  [NUM_PORTS];
   port_mask_t credit_up; // credits the router returns to its upstream senders
   link_t      out_link [NUM_PORTS];
   port_mask_t credit_down; // credits the downstream neighbors return

   flit_t       exp_q [NUM_PORTS][NUM_PORTS][$]; // expected flits by input, then output
   int          in_credits [NUM_PORTS]; // credits each upstream sender holds
   int          ds_pending [NUM_PORTS]; // flits sent downstream and not yet credited
   int          inject_count;
   int unsigned lcg_state;

   clock_gen #(
      .PERIOD_NS (40)
   ) u_clock_gen (
      .clk_o (clk)
   );

   mesh_router #(
      .ROUTER_X  (ROUTER_X),
      .ROUTER_Y  (ROUTER_Y),
      .BUF_DEPTH (BUF_DEPTH)
   ) UUT (
      .clk_i      (clk),
      .rst_i      (rst),
      .in_link_i  (in_link),
      .credit_o   (credit_up),
      .out_link_o (out_link),
      .credit_i   (credit_down)
   );

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state >> 16; // the low bits of the state repeat too soon
   endfunction

   function automatic bit chance(input int unsigned one_in);
      return (lcg_next() % one_in) == 0;
   endfunction

   // dimension-ordered routing, x first, north is the larger y
   function automatic int xy_route(input flit_t f);
      if (f.dst_x > ROUTER_X) return int'(PORT_E);
      if (f.dst_x < ROUTER_X) return int'(PORT_W);
      if (f.dst_y > ROUTER_Y) return int'(PORT_N);
      if (f.dst_y < ROUTER_Y) return int'(PORT_S);
      return int'(PORT_L);
   endfunction

   function automatic flit_t legal_flit(input int p);
      flit_t f;
      f.dst_x   = COORD_W'(lcg_next());
      f.dst_y   = COORD_W'(lcg_next());
      f.payload = PAYLOAD_W'(lcg_next());
      // a flit may never turn back out of the port it came in on
      if (xy_route(f) == p) begin
         if (p == int'(PORT_N) || p == int'(PORT_S)) begin
            f.dst_y = ROUTER_Y; // now routed to local
         end else if (p == int'(PORT_W) || p == int'(PORT_E)) begin
            f.dst_x = ROUTER_X; // now resolved in y
         end else begin
            f.dst_x = ROUTER_X ^ COORD_W'(1);
         end
      end
      return f;
   endfunction

   // nothing moves on either side and every downstream slot is free
   function automatic bit router_idle();
      for (int p = 0; p < NUM_PORTS; p++) begin
         if (ds_pending[p] != 0 || out_link[p].valid || credit_up[p]) return 1'b0;
      end
      return 1'b1;
   endfunction

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("SIMULATION FAILED");
      $fatal(1, "testbench stopped at the first failure");
   endtask

   task automatic check_value(input string name, input int got, input int expected);
      if (got != expected) begin
         stop_with_failure($sformatf("error at %0t ns: %s is %0d, expected %0d",
                                     $time, name, got, expected));
      end
   endtask

   task automatic sample_outputs();
      flit_t f;
      bit    found;
      for (int q = 0; q < NUM_PORTS; q++) begin
         if (out_link[q].valid) begin
            f = out_link[q].flit;
            check_value($sformatf("route of flit on out_link_o[%0d]", q), xy_route(f), q);
            found = 1'b0;
            // only the oldest flit of each input may leave next
            for (int i = 0; i < NUM_PORTS; i++) begin
               if (!found && exp_q[i][q].size() > 0 && exp_q[i][q][0] == f) begin
                  void'(exp_q[i][q].pop_front());
                  found = 1'b1;
               end
            end
            if (!found) begin
               stop_with_failure($sformatf(
                  "flit %h left on output %0d but was never sent there or broke order",
                  f, q));
            end
            ds_pending[q]++;
            if (ds_pending[q] > BUF_DEPTH) begin
               stop_with_failure($sformatf(
                  "output %0d sent a flit at %0t ns without a downstream credit", q, $time));
            end
         end
         if (credit_up[q]) begin
            in_credits[q]++;
            if (in_credits[q] > BUF_DEPTH) begin
               stop_with_failure($sformatf(
                  "input %0d returned more credits than flits it accepted", q));
            end
         end
      end
   endtask

   task automatic drive_inputs(input bit inject_en, input bit withhold);
      flit_t f;
      int    route;
      for (int p = 0; p < NUM_PORTS; p++) begin
         in_link[p] = '0;
         if (inject_en && in_credits[p] > 0 && chance(2)) begin
            f                = legal_flit(p);
            route            = xy_route(f);
            in_link[p].valid = 1'b1;
            in_link[p].flit  = f;
            exp_q[p][route].push_back(f);
            in_credits[p]--;
            inject_count++;
         end
         credit_down[p] = 1'b0;
         // the downstream buffer frees a slot after a random delay
         if (!withhold && ds_pending[p] > 0 && chance(3)) begin
            credit_down[p] = 1'b1;
            ds_pending[p]--;
         end
      end
   endtask

   task automatic run_cycle(input bit inject_en, input bit withhold);
      @(posedge clk);
      #1;
      sample_outputs();
      #1;
      drive_inputs(inject_en, withhold);
   endtask

   initial begin : main
      int idle_run;
      lcg_state    = 32'd70995;
      rst          = 1'b1;
      credit_down  = '0;
      inject_count = 0;
      for (int p = 0; p < NUM_PORTS; p++) begin
         in_link[p]    = '0;
         in_credits[p] = BUF_DEPTH;
         ds_pending[p] = 0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      #2;
      rst = 1'b0;

      // nothing has been driven yet, so both sides of the router stay quiet
      @(posedge clk);
      #1;
      for (int p = 0; p < NUM_PORTS; p++) begin
         check_value($sformatf("out_link_o[%0d].valid", p), int'(out_link[p].valid), 0);
         check_value($sformatf("credit_o[%0d]", p), int'(credit_up[p]), 0);
      end
      #1;

      for (int c = 0; c < TRAFFIC_CYCLES; c++) begin
         run_cycle(1'b1, (c % HOLD_PERIOD) >= (HOLD_PERIOD - HOLD_LENGTH));
      end

      // keep returning credits until the router has been idle for a while
      idle_run = 0;
      while (idle_run < QUIET_CYCLES) begin
         run_cycle(1'b0, 1'b0);
         if (router_idle()) begin
            idle_run++;
         end else begin
            idle_run = 0;
         end
      end

      for (int p = 0; p < NUM_PORTS; p++) begin
         for (int q = 0; q < NUM_PORTS; q++) begin
            check_value($sformatf("flits left from input %0d to output %0d", p, q),
                        exp_q[p][q].size(), 0);
         end
         check_value($sformatf("credits held by sender %0d", p), in_credits[p], BUF_DEPTH);
      end

      $display("SIMULATION PASSED");
      $finish;
   end

   initial begin : watchdog
      repeat (RESET_CYCLES + TRAFFIC_CYCLES + 2) @(posedge clk);
      // the drain gets 40 cycles for every flit injected
      repeat (inject_count * 40 + DRAIN_MARGIN) @(posedge clk);
      stop_with_failure("timeout: the router did not deliver all flits and credits in time");
   end

endmodule

`default_nettype wire

// File: files.f
common/noc_pkg.sv
router/input_port.sv
router/switch_allocator.sv
router/crossbar_switch.sv
router/output_port.sv
source/mesh_router.sv
bench/clock_gen.sv
bench/tb_mesh_router.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ns
TOP       = tb_mesh_router
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
